/* Makefile */
# Verilator build, run, lint and clean for the scalar LCM unit

VERILATOR  ?= verilator
TOP        ?= ntm_scalar_lcm_tb
RTL_TOP    ?= ntm_scalar_lcm
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?=
LINT_FLAGS ?=
PASS_TEXT  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -j 0 $(VFLAGS) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR)

# Pass only when the testbench printed the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
source/ntm_math_pkg.sv
source/ntm_lcm_ctrl_pkg.sv
source/ntm_scalar_gcd.sv
source/ntm_scalar_divider.sv
source/ntm_scalar_mod_multiplier.sv
source/ntm_scalar_lcm.sv
tb/ntm_scalar_lcm_tb.sv

/* source/ntm_lcm_ctrl_pkg.sv */
/*
 * State encodings for the LCM sequencer and the GCD unit
 */

package ntm_lcm_ctrl_pkg;

  // LCM controller, one state per arithmetic phase
  typedef enum logic [2:0] {
    IDLE,
    RUN_GCD,
    RUN_QUOT,
    RUN_RED_Q,
    RUN_RED_B,
    RUN_MUL,
    DONE
  } lcm_state_t;

  // Binary GCD phases
  typedef enum logic [1:0] {
    GCD_IDLE,
    GCD_STRIP,
    GCD_REDUCE,
    GCD_FINISH
  } gcd_state_t;

endpackage

/* source/ntm_math_pkg.sv */
/*
 * Arithmetic definitions shared by the scalar units
 * Operand width limit and the bit-step counter type
 */

package ntm_math_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Width limits
  ////////////////////////////////////////////////////////////////////////////

  // Largest operand width any unit is built for
  localparam int DATA_SIZE_MAX = 512;

  // Counter must reach DATA_SIZE_MAX itself for the final step
  localparam int STEP_COUNT_W = $clog2(DATA_SIZE_MAX + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // Bit steps of the divider and the multiplier
  // Also holds the GCD factor-of-two count
  typedef logic [STEP_COUNT_W-1:0] step_count_t;

endpackage

/* source/ntm_scalar_divider.sv */
/*
 * Scalar restoring divider
 * One quotient bit per cycle, MSB first, results after DATA_SIZE+1 cycles
 */

`timescale 1ns/1ps

module ntm_scalar_divider
  import ntm_math_pkg::*;
#(
  parameter int DATA_SIZE = 512
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic [DATA_SIZE-1:0] DIVIDEND_IN,
  input  logic [DATA_SIZE-1:0] DIVISOR_IN,
  output logic [DATA_SIZE-1:0] QUOTIENT_OUT,
  output logic [DATA_SIZE-1:0] REMAINDER_OUT
);

  logic                 busy;
  step_count_t          step_cnt;
  logic                 step_last;

  // Dividend shifts out MSB first while quotient bits shift in
  logic [DATA_SIZE-1:0] quo_r;
  logic [DATA_SIZE-1:0] rem_r;
  logic [DATA_SIZE-1:0] div_r;

  // Partial remainder with next dividend bit, and trial difference
  logic [DATA_SIZE:0]   trial;
  logic [DATA_SIZE:0]   diff;

  assign step_last = (step_cnt == step_count_t'(DATA_SIZE));
  assign trial     = {rem_r, quo_r[DATA_SIZE-1]};
  assign diff      = trial - {1'b0, div_r};

  ////////////////////////////////////////////////////////////////////////////
  // Step sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      step_cnt <= '0;
      READY    <= 1'b0;
    end else begin
      READY <= 1'b0;
      if (!busy) begin
        if (START) begin
          busy     <= 1'b1;
          step_cnt <= '0;
        end
      end else if (step_last) begin
        // Presentation cycle
        busy  <= 1'b0;
        READY <= 1'b1;
      end else begin
        step_cnt <= step_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Restoring division
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (!busy) begin
      if (START) begin
        quo_r <= DIVIDEND_IN;
        rem_r <= '0;
        div_r <= DIVISOR_IN;
      end
    end else if (step_last) begin
      QUOTIENT_OUT  <= quo_r;
      REMAINDER_OUT <= rem_r;
    end else if (!diff[DATA_SIZE]) begin
      // Divisor fits, keep the difference
      rem_r <= diff[DATA_SIZE-1:0];
      quo_r <= {quo_r[DATA_SIZE-2:0], 1'b1};
    end else begin
      // Restore the shifted remainder
      rem_r <= trial[DATA_SIZE-1:0];
      quo_r <= {quo_r[DATA_SIZE-2:0], 1'b0};
    end
  end

endmodule

/* source/ntm_scalar_gcd.sv */
/*
 * Scalar binary GCD unit
 * Stein's algorithm, one shift or subtract per cycle
 * Operands are nonzero, latency depends on their values
 */

`timescale 1ns/1ps

module ntm_scalar_gcd
  import ntm_math_pkg::*, ntm_lcm_ctrl_pkg::*;
#(
  parameter int DATA_SIZE = 512
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic [DATA_SIZE-1:0] DATA_A_IN,
  input  logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  gcd_state_t           gcd_state;

  // Working copies of the operands
  logic [DATA_SIZE-1:0] a_r;
  logic [DATA_SIZE-1:0] b_r;

  // Common factors of two removed in STRIP
  step_count_t          shift_r;

  logic                 both_even;
  logic                 any_zero;

  assign both_even = !a_r[0] && !b_r[0];
  assign any_zero  = (a_r == '0) || (b_r == '0);

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      gcd_state <= GCD_IDLE;
      READY     <= 1'b0;
    end else begin
      READY <= 1'b0;
      case (gcd_state)
        GCD_IDLE: begin
          if (START) begin
            gcd_state <= GCD_STRIP;
          end
        end
        GCD_STRIP: begin
          // Stays until at least one value is odd
          if (!both_even) begin
            gcd_state <= GCD_REDUCE;
          end
        end
        GCD_REDUCE: begin
          if (any_zero) begin
            gcd_state <= GCD_FINISH;
          end
        end
        GCD_FINISH: begin
          READY     <= 1'b1;
          gcd_state <= GCD_IDLE;
        end
        default: begin
          gcd_state <= GCD_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (gcd_state)
      GCD_IDLE: begin
        if (START) begin
          a_r     <= DATA_A_IN;
          b_r     <= DATA_B_IN;
          shift_r <= '0;
        end
      end
      GCD_STRIP: begin
        if (both_even) begin
          a_r     <= a_r >> 1;
          b_r     <= b_r >> 1;
          shift_r <= shift_r + 1'b1;
        end
      end
      GCD_REDUCE: begin
        // Only one odd factor left in common from here on
        if (!any_zero) begin
          if (!a_r[0]) begin
            a_r <= a_r >> 1;
          end else if (!b_r[0]) begin
            b_r <= b_r >> 1;
          end else if (a_r >= b_r) begin
            a_r <= a_r - b_r;
          end else begin
            b_r <= b_r - a_r;
          end
        end
      end
      GCD_FINISH: begin
        // One value is zero so the OR picks the other
        DATA_OUT <= (a_r | b_r) << shift_r;
      end
      default: begin
      end
    endcase
  end

endmodule

/* source/ntm_scalar_lcm.sv */
/*
 * Scalar LCM unit, DATA_OUT = lcm(a, b) mod m
 * Sequences GCD, three divisions and a modular multiply
 * Zero operands give zero without starting any unit
 */

`timescale 1ns/1ps

module ntm_scalar_lcm
  import ntm_lcm_ctrl_pkg::*;
#(
  parameter int DATA_SIZE = 512
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] DATA_A_IN,
  input  logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  lcm_state_t           lcm_state;
  logic                 in_zero;
  logic                 zero_r;

  // Captured operands and reduced values
  logic [DATA_SIZE-1:0] a_r;
  logic [DATA_SIZE-1:0] b_r;
  logic [DATA_SIZE-1:0] m_r;
  logic [DATA_SIZE-1:0] q_mod_r;
  logic [DATA_SIZE-1:0] b_mod_r;

  // Unit handshakes and results
  logic                 gcd_start;
  logic                 gcd_ready;
  logic [DATA_SIZE-1:0] gcd_out;
  logic                 div_start;
  logic                 div_ready;
  logic [DATA_SIZE-1:0] div_dividend;
  logic [DATA_SIZE-1:0] div_divisor;
  logic [DATA_SIZE-1:0] div_quotient;
  logic [DATA_SIZE-1:0] div_remainder;
  logic                 mul_start;
  logic                 mul_ready;
  logic [DATA_SIZE-1:0] mul_out;

  assign in_zero = (DATA_A_IN == '0) || (DATA_B_IN == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      lcm_state <= IDLE;
      zero_r    <= 1'b0;
      gcd_start <= 1'b0;
      div_start <= 1'b0;
      mul_start <= 1'b0;
      READY     <= 1'b0;
      DATA_OUT  <= '0;
    end else begin
      READY     <= 1'b0;
      gcd_start <= 1'b0;
      div_start <= 1'b0;
      mul_start <= 1'b0;
      case (lcm_state)
        IDLE: begin
          if (START) begin
            zero_r    <= in_zero;
            gcd_start <= !in_zero;
            lcm_state <= RUN_GCD;
          end
        end
        RUN_GCD: begin
          // Zero operand skips every unit
          if (zero_r) begin
            lcm_state <= DONE;
          end else if (gcd_ready) begin
            div_start <= 1'b1;
            lcm_state <= RUN_QUOT;
          end
        end
        RUN_QUOT: begin
          // q = a / g ready
          if (div_ready) begin
            div_start <= 1'b1;
            lcm_state <= RUN_RED_Q;
          end
        end
        RUN_RED_Q: begin
          if (div_ready) begin
            div_start <= 1'b1;
            lcm_state <= RUN_RED_B;
          end
        end
        RUN_RED_B: begin
          if (div_ready) begin
            mul_start <= 1'b1;
            lcm_state <= RUN_MUL;
          end
        end
        RUN_MUL: begin
          if (mul_ready) begin
            lcm_state <= DONE;
          end
        end
        DONE: begin
          // Multiplier output is held since its READY
          DATA_OUT  <= zero_r ? '0 : mul_out;
          READY     <= 1'b1;
          lcm_state <= IDLE;
        end
        default: begin
          lcm_state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operand capture and reduced values
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if ((lcm_state == IDLE) && START) begin
      a_r <= DATA_A_IN;
      b_r <= DATA_B_IN;
      m_r <= MODULO_IN;
    end
    // q mod m
    if ((lcm_state == RUN_RED_Q) && div_ready) begin
      q_mod_r <= div_remainder;
    end
    // b mod m
    if ((lcm_state == RUN_RED_B) && div_ready) begin
      b_mod_r <= div_remainder;
    end
  end

  // Divider operands follow the phase, sampled on div_start
  always_comb begin
    case (lcm_state)
      RUN_RED_Q: begin
        div_dividend = div_quotient;
        div_divisor  = m_r;
      end
      RUN_RED_B: begin
        div_dividend = b_r;
        div_divisor  = m_r;
      end
      default: begin
        div_dividend = a_r;
        div_divisor  = gcd_out;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic units
  ////////////////////////////////////////////////////////////////////////////

  ntm_scalar_gcd #(
    .DATA_SIZE(DATA_SIZE)
  ) gcd_inst (
    .CLK      (CLK),
    .RST      (RST),
    .START    (gcd_start),
    .READY    (gcd_ready),
    .DATA_A_IN(a_r),
    .DATA_B_IN(b_r),
    .DATA_OUT (gcd_out)
  );

  ntm_scalar_divider #(
    .DATA_SIZE(DATA_SIZE)
  ) divider_inst (
    .CLK          (CLK),
    .RST          (RST),
    .START        (div_start),
    .READY        (div_ready),
    .DIVIDEND_IN  (div_dividend),
    .DIVISOR_IN   (div_divisor),
    .QUOTIENT_OUT (div_quotient),
    .REMAINDER_OUT(div_remainder)
  );

  ntm_scalar_mod_multiplier #(
    .DATA_SIZE(DATA_SIZE)
  ) mod_multiplier_inst (
    .CLK      (CLK),
    .RST      (RST),
    .START    (mul_start),
    .READY    (mul_ready),
    .MODULO_IN(m_r),
    .DATA_A_IN(q_mod_r),
    .DATA_B_IN(b_mod_r),
    .DATA_OUT (mul_out)
  );

endmodule

/* source/ntm_scalar_mod_multiplier.sv */
/*
 * Scalar interleaved modular multiplier
 * Computes a * b mod m for a and b already below m
 * Results after DATA_SIZE+1 cycles
 */

`timescale 1ns/1ps

module ntm_scalar_mod_multiplier
  import ntm_math_pkg::*;
#(
  parameter int DATA_SIZE = 512
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  output logic                 READY,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic [DATA_SIZE-1:0] DATA_A_IN,
  input  logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  logic                 busy;
  step_count_t          step_cnt;
  logic                 step_last;

  // Multiplier scanned MSB first
  logic [DATA_SIZE-1:0] a_r;
  logic [DATA_SIZE-1:0] b_r;
  logic [DATA_SIZE-1:0] m_r;
  logic [DATA_SIZE-1:0] acc_r;

  // One extra bit for the carry of doubling and adding
  logic [DATA_SIZE:0]   dbl;
  logic [DATA_SIZE:0]   dbl_red;
  logic [DATA_SIZE:0]   sum;
  logic [DATA_SIZE:0]   sum_red;

  assign step_last = (step_cnt == step_count_t'(DATA_SIZE));

  ////////////////////////////////////////////////////////////////////////////
  // Step datapath
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    dbl     = {acc_r, 1'b0};
    dbl_red = (dbl >= {1'b0, m_r}) ? dbl - {1'b0, m_r} : dbl;
    // Add b only when the scanned bit is set
    sum     = dbl_red + (a_r[DATA_SIZE-1] ? {1'b0, b_r} : '0);
    sum_red = (sum >= {1'b0, m_r}) ? sum - {1'b0, m_r} : sum;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Step sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      step_cnt <= '0;
      READY    <= 1'b0;
    end else begin
      READY <= 1'b0;
      if (!busy) begin
        if (START) begin
          busy     <= 1'b1;
          step_cnt <= '0;
        end
      end else if (step_last) begin
        busy  <= 1'b0;
        READY <= 1'b1;
      end else begin
        step_cnt <= step_cnt + 1'b1;
      end
    end
  end

  // Operand latch, accumulate, present
  always_ff @(posedge CLK) begin
    if (!busy) begin
      if (START) begin
        a_r   <= DATA_A_IN;
        b_r   <= DATA_B_IN;
        m_r   <= MODULO_IN;
        acc_r <= '0;
      end
    end else if (step_last) begin
      DATA_OUT <= acc_r;
    end else begin
      // Accumulator stays below m after each step
      acc_r <= sum_red[DATA_SIZE-1:0];
      a_r   <= {a_r[DATA_SIZE-2:0], 1'b0};
    end
  end

endmodule

/* tb/ntm_scalar_lcm_tb.sv */
/*
 * Testbench for the scalar LCM unit at DATA_SIZE 32
 * Random and directed operands checked against a Euclid-based model
 */

`timescale 1ns/1ps

module ntm_scalar_lcm_tb;

  localparam int DATA_SIZE    = 32;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_DIRECTED = 12;
  // GCD up to 64, divider 3 x 33, multiplier 33, sequencer overhead, with margin
  localparam int OP_CYCLES    = 400;
  // Busy test watches two operations' worth of cycles for a second READY
  localparam int WATCH_CYCLES = 2 * OP_CYCLES;
  localparam int NUM_OPS      = 1 + NUM_RANDOM + NUM_DIRECTED + 1 + WATCH_CYCLES / OP_CYCLES;
  localparam int TIMEOUT_CYCLES = NUM_OPS * OP_CYCLES;

  logic                 CLK;
  logic                 RST;
  logic                 START;
  logic                 READY;
  logic [DATA_SIZE-1:0] MODULO_IN;
  logic [DATA_SIZE-1:0] DATA_A_IN;
  logic [DATA_SIZE-1:0] DATA_B_IN;
  logic [DATA_SIZE-1:0] DATA_OUT;

  int cycle_count  = 0;
  int check_count  = 0;
  int error_count  = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  ntm_scalar_lcm #(
    .DATA_SIZE(DATA_SIZE)
  ) ntm_scalar_lcm_inst (
    .CLK      (CLK),
    .RST      (RST),
    .START    (START),
    .READY    (READY),
    .MODULO_IN(MODULO_IN),
    .DATA_A_IN(DATA_A_IN),
    .DATA_B_IN(DATA_B_IN),
    .DATA_OUT (DATA_OUT)
  );

  // 8 ns clock
  always #4 CLK = ~CLK;

  // Run limit over all tests
  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and checking
  ////////////////////////////////////////////////////////////////////////////

  // lcm(a, b) mod m, zero for a zero operand
  function automatic logic [63:0] lcm_mod_model(input logic [63:0] a, input logic [63:0] b,
                                                input logic [63:0] m);
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] t;
    if ((a == 64'd0) || (b == 64'd0)) begin
      return 64'd0;
    end
    x = a;
    y = b;
    // Euclid
    while (y != 64'd0) begin
      t = x % y;
      x = y;
      y = t;
    end
    return ((a / x) * b) % m;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count = check_count + 1;
    if (expected !== actual) begin
      $display("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      error_count = error_count + 1;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      $display("test %s: ok", name);
      tests_passed = tests_passed + 1;
    end else begin
      $display("test %s: %0d errors", name, error_count - errors_before);
      tests_failed = tests_failed + 1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Called 1 ns after a rising edge, returns 1 ns after the READY edge
  task automatic run_op(input string name, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] m, output logic [31:0] result, output int latency);
    int cycles;
    DATA_A_IN = a;
    DATA_B_IN = b;
    MODULO_IN = m;
    START     = 1'b1;
    @(posedge CLK);
    #1;
    START  = 1'b0;
    cycles = 0;
    // Cycles counted from the edge that sampled START
    while (!READY && (cycles < OP_CYCLES)) begin
      @(posedge CLK);
      #1;
      cycles = cycles + 1;
    end
    if (!READY) begin
      $display("%s: DUT never raised READY within %0d cycles", name, OP_CYCLES);
      error_count = error_count + 1;
    end
    result  = DATA_OUT;
    latency = cycles;
  endtask

  task automatic check_op(input string name, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] m);
    logic [31:0] result;
    int          latency;
    run_op(name, a, b, m, result, latency);
    check_value(name, lcm_mod_model(64'(a), 64'(b), 64'(m)), 64'(result));
  endtask

  initial begin
    int          errors_before;
    int          n_above;
    int          n_below;
    int          ready_count;
    int          latency;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] m;
    logic [31:0] result;
    logic [31:0] first_value;
    logic [63:0] lcm_full;

    CLK       = 1'b0;
    RST       = 1'b1;
    START     = 1'b0;
    MODULO_IN = 32'd1;
    DATA_A_IN = 32'd0;
    DATA_B_IN = 32'd0;
    void'($urandom(32'h79820f90));

    // Reset held for two cycles
    errors_before = error_count;
    repeat (2) @(posedge CLK);
    #1;
    check_value("reset_state READY in reset", 64'd0, 64'(READY));
    check_value("reset_state DATA_OUT in reset", 64'd0, 64'(DATA_OUT));
    RST = 1'b0;
    @(posedge CLK);
    #1;
    check_value("reset_state READY", 64'd0, 64'(READY));
    check_value("reset_state DATA_OUT", 64'd0, 64'(DATA_OUT));
    report_test("reset_state", errors_before);

    // 16-bit operands, full and small moduli alternate
    errors_before = error_count;
    n_above = 0;
    n_below = 0;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      a = $urandom() & 32'h0000_FFFF;
      b = $urandom() & 32'h0000_FFFF;
      if ((i % 2) == 0) begin
        m = ($urandom() % 32'hFFFF_FFFF) + 32'd1;
      end else begin
        m = ($urandom() & 32'h0000_FFFF) + 32'd1;
      end
      lcm_full = lcm_mod_model(64'(a), 64'(b), 64'hFFFF_FFFF_FFFF_FFFF);
      if (lcm_full >= 64'(m)) begin
        n_above = n_above + 1;
      end else begin
        n_below = n_below + 1;
      end
      check_op($sformatf("random_operands[%0d]", i), a, b, m);
    end
    if ((n_above == 0) || (n_below == 0)) begin
      $display("random_operands: stimulus missed either lcm >= m or lcm < m");
      error_count = error_count + 1;
    end
    report_test("random_operands", errors_before);

    // Zero path answers two cycles after START
    errors_before = error_count;
    run_op("zero_operands a", 32'd0, 32'd1234, 32'd977, result, latency);
    check_value("zero_operands a value", 64'd0, 64'(result));
    check_value("zero_operands a latency", 64'd2, 64'(latency));
    run_op("zero_operands b", 32'd5678, 32'd0, 32'd977, result, latency);
    check_value("zero_operands b value", 64'd0, 64'(result));
    check_value("zero_operands b latency", 64'd2, 64'(latency));
    run_op("zero_operands both", 32'd0, 32'd0, 32'hFFFF_FFFF, result, latency);
    check_value("zero_operands both value", 64'd0, 64'(result));
    check_value("zero_operands both latency", 64'd2, 64'(latency));
    report_test("zero_operands", errors_before);

    errors_before = error_count;
    check_op("divisibility equal", 32'd12345, 32'd12345, 32'd1000003);
    check_op("divisibility multiple", 32'd7, 32'd63007, 32'hFFFF_FFFF);
    check_op("divisibility divisor", 32'd3000, 32'd300, 32'd1001);
    check_op("divisibility coprime", 32'd65521, 32'd65519, 32'd4000037);
    check_op("divisibility large primes", 32'd104729, 32'd1299709, 32'hFFFF_FFFB);
    report_test("divisibility", errors_before);

    // Literal values double as a check on the model
    errors_before = error_count;
    run_op("modulus_edges m one", 32'd1234, 32'd5678, 32'd1, result, latency);
    check_value("modulus_edges m one", 64'd0, 64'(result));
    run_op("modulus_edges small", 32'd12, 32'd18, 32'hFFFF_FFFF, result, latency);
    check_value("modulus_edges small", 64'd36, 64'(result));
    run_op("modulus_edges wide", 32'd65535, 32'd65534, 32'hFFFF_FFFF, result, latency);
    check_value("modulus_edges wide", 64'd4294770690, 64'(result));
    check_op("modulus_edges model", 32'd65535, 32'd65534, 32'hFFFF_FFFF);
    report_test("modulus_edges", errors_before);

    // Second START a few cycles into the first operation
    errors_before = error_count;
    DATA_A_IN = 32'd360;
    DATA_B_IN = 32'd84;
    MODULO_IN = 32'd1009;
    START     = 1'b1;
    @(posedge CLK);
    #1;
    START = 1'b0;
    repeat (5) begin
      @(posedge CLK);
      #1;
    end
    DATA_A_IN = 32'd4321;
    DATA_B_IN = 32'd999;
    MODULO_IN = 32'd77;
    START     = 1'b1;
    @(posedge CLK);
    #1;
    START       = 1'b0;
    ready_count = 0;
    first_value = 32'd0;
    for (int i = 0; i < WATCH_CYCLES; i++) begin
      if (READY) begin
        ready_count = ready_count + 1;
        if (ready_count == 1) begin
          first_value = DATA_OUT;
        end
      end
      @(posedge CLK);
      #1;
    end
    if (ready_count == 0) begin
      $display("busy_protection: DUT never raised READY for the first operation");
      error_count = error_count + 1;
    end else begin
      check_value("busy_protection ready count", 64'd1, 64'(ready_count));
      check_value("busy_protection value", lcm_mod_model(64'd360, 64'd84, 64'd1009),
                  64'(first_value));
    end
    report_test("busy_protection", errors_before);

    $display("summary: %0d tests ok, %0d tests with errors, %0d checks, %0d errors",
             tests_passed, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
